// ==== common/mat_pkg.sv ====
package mat_pkg;

  //////////////////////////////////////////////////////////////////////
  // Array and memory sizes
  //////////////////////////////////////////////////////////////////////

  localparam int MAT_SIZE = 4;
  localparam int ELEM_W   = 8;
  localparam int ADDR_W   = $clog2(MAT_SIZE);

  // Last product needs both skews plus the grid diagonal to settle
  localparam int DRAIN_CYCLES = 2 * MAT_SIZE;

  // Clear, feed, drain, write C, then the done_ack register
  localparam int MUL_LATENCY = 1 + MAT_SIZE + DRAIN_CYCLES + MAT_SIZE + 1;

  // Memory read plus output register
  localparam int READ_LATENCY = 2;

  //////////////////////////////////////////////////////////////////////
  // Data types
  //////////////////////////////////////////////////////////////////////

  // One matrix element
  typedef logic [ELEM_W-1:0] elem_t;

  // One memory word, a full row or column
  typedef logic [MAT_SIZE*ELEM_W-1:0] row_t;

  // Word address inside a row memory
  typedef logic [ADDR_W-1:0] addr_t;

  // One host command per cycle
  typedef struct packed {
    logic  wr_a;
    logic  wr_b;
    logic  rd_c;
    addr_t addr;
    row_t  data;
  } host_cmd_t;

  // Controller sequence
  typedef enum logic [2:0] {
    IDLE,
    CLEAR,
    FEED,
    DRAIN,
    WRITE_C,
    DONE
  } ctrl_state_t;

endpackage

// ==== matrix_multiplication.f ====
common/mat_pkg.sv
verilog/row_ram.sv
systolic/systolic_pe.sv
systolic/systolic_array.sv
verilog/mat_mul_ctrl.sv
verilog/matrix_multiplication.sv
tb/mat_mul_properties.sv
tb/matrix_multiplication_tb.sv

// ==== systolic/systolic_array.sv ====
`timescale 1ns/10ps

module systolic_array
  import mat_pkg::*;
(
  input  logic  clk_mem,
  input  logic  reset,
  input  logic  clear,
  input  row_t  a_col,
  input  row_t  b_row,
  input  logic  operand_valid,
  input  addr_t res_row,
  output row_t  res_data
);

  // Skewed operands at the array edge
  elem_t a_edge [MAT_SIZE];
  elem_t b_edge [MAT_SIZE];

  // Pass links between cells and the accumulator grid
  elem_t a_link [MAT_SIZE][MAT_SIZE];
  elem_t b_link [MAT_SIZE][MAT_SIZE];
  elem_t acc_grid [MAT_SIZE][MAT_SIZE];

  //////////////////////////////////////////////////////////////////////
  // Input skew
  //////////////////////////////////////////////////////////////////////

  // Lane i delays A byte i and B byte i by i cycles
  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_skew
    logic [2*ELEM_W-1:0] stage [0:i];

    // Zeros outside the feed window
    assign stage[0] = operand_valid ?
                      {a_col[i*ELEM_W +: ELEM_W], b_row[i*ELEM_W +: ELEM_W]} : '0;

    for (genvar d = 1; d <= i; d++) begin : g_dly
      always_ff @(posedge clk_mem) begin
        if (reset || clear) begin
          stage[d] <= '0;
        end else begin
          stage[d] <= stage[d-1];
        end
      end
    end

    assign a_edge[i] = stage[i][2*ELEM_W-1:ELEM_W];
    assign b_edge[i] = stage[i][ELEM_W-1:0];
  end

  //////////////////////////////////////////////////////////////////////
  // Processing element grid
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < MAT_SIZE; i++) begin : g_row
    for (genvar j = 0; j < MAT_SIZE; j++) begin : g_col
      elem_t a_src;
      elem_t b_src;

      // First column and first row take the skewed edge
      assign a_src = (j == 0) ? a_edge[i] : a_link[i][(j == 0) ? 0 : j-1];
      assign b_src = (i == 0) ? b_edge[j] : b_link[(i == 0) ? 0 : i-1][j];

      systolic_pe pe_i (
        .clk_mem (clk_mem),
        .reset   (reset),
        .clear   (clear),
        .a_in    (a_src),
        .b_in    (b_src),
        .a_out   (a_link[i][j]),
        .b_out   (b_link[i][j]),
        .acc     (acc_grid[i][j])
      );
    end
  end

  // Row of C selected for the write back
  always_comb begin
    for (int j = 0; j < MAT_SIZE; j++) begin
      res_data[j*ELEM_W +: ELEM_W] = acc_grid[res_row][j];
    end
  end

endmodule

// ==== systolic/systolic_pe.sv ====
`timescale 1ns/10ps

module systolic_pe
  import mat_pkg::*;
(
  input  logic  clk_mem,
  input  logic  reset,
  input  logic  clear,
  input  elem_t a_in,
  input  elem_t b_in,
  output elem_t a_out,
  output elem_t b_out,
  output elem_t acc
);

  //////////////////////////////////////////////////////////////////////
  // Operand pass registers
  //////////////////////////////////////////////////////////////////////

  // A moves one column right, B one row down, each cycle
  always_ff @(posedge clk_mem) begin
    if (reset || clear) begin
      a_out <= '0;
      b_out <= '0;
    end else begin
      a_out <= a_in;
      b_out <= b_in;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Multiply-accumulate
  //////////////////////////////////////////////////////////////////////

  // Sum wraps at ELEM_W bits
  // Zero operands between runs leave the result in place
  always_ff @(posedge clk_mem) begin
    if (reset || clear) begin
      acc <= '0;
    end else begin
      acc <= acc + a_in * b_in;
    end
  end

endmodule

// ==== tb/mat_mul_properties.sv ====
`timescale 1ns/10ps

module mat_mul_properties (
  input logic clk_mem,
  input logic reset,
  input logic start_req,
  input logic done_ack,
  input logic rd_valid
);

  // Property failures seen so far
  int unsigned fail_count = 0;

  //////////////////////////////////////////////////////////////////////
  // Reset state
  //////////////////////////////////////////////////////////////////////

  reset_quiet: assert property (@(posedge clk_mem) reset |=> (!done_ack && !rd_valid))
    else begin
      $error("done_ack or rd_valid high during or right after reset");
      fail_count++;
    end

  //////////////////////////////////////////////////////////////////////
  // Four-phase handshake
  //////////////////////////////////////////////////////////////////////

  // Ack only rises in answer to a request
  ack_needs_req: assert property (@(posedge clk_mem) disable iff (reset)
                                  $rose(done_ack) |-> $past(start_req))
    else begin
      $error("done_ack rose while start_req was low");
      fail_count++;
    end

  ack_drops: assert property (@(posedge clk_mem) disable iff (reset)
                              (done_ack && !start_req) |=> !done_ack)
    else begin
      $error("done_ack did not fall the cycle after start_req went low");
      fail_count++;
    end

endmodule

// ==== tb/matrix_multiplication_tb.sv ====
`timescale 1ns/10ps

module matrix_multiplication_tb
  import mat_pkg::*;
();

  localparam int CLK_PERIOD       = 20;
  localparam int RESET_CYCLES     = 10;
  localparam int NUM_TESTS        = 5;
  localparam logic [31:0] SEED    = 32'he440_beb7;
  // Operand writes, writes during ack, row reads and handshake overhead
  localparam int LOAD_READ_CYCLES = 3 * MAT_SIZE + MAT_SIZE * READ_LATENCY + 4;
  localparam int WATCHDOG_NS      =
    (RESET_CYCLES + NUM_TESTS * (MUL_LATENCY + LOAD_READ_CYCLES) * 2) * CLK_PERIOD;

  // Element [i][k] of a matrix
  typedef logic [MAT_SIZE-1:0][MAT_SIZE-1:0][ELEM_W-1:0] mat_t;

  typedef struct packed {
    logic [8*16-1:0] name;
    logic            load_a;
    logic            load_b;
    logic            use_lfsr;
    logic            poke_a;
    mat_t            a;
    mat_t            b;
  } test_t;

  logic        clk_mem;
  logic        reset;
  logic        start_req;
  host_cmd_t   host_cmd;
  logic        done_ack;
  row_t        rd_data;
  logic        rd_valid;
  logic [31:0] lfsr;
  mat_t        cur_a;
  mat_t        cur_b;
  test_t       tests [NUM_TESTS];

  matrix_multiplication matrix_multiplication_i (
    .clk_mem   (clk_mem),
    .reset     (reset),
    .host_cmd  (host_cmd),
    .start_req (start_req),
    .done_ack  (done_ack),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

  bind matrix_multiplication mat_mul_properties props_i (
    .clk_mem   (clk_mem),
    .reset     (reset),
    .start_req (start_req),
    .done_ack  (done_ack),
    .rd_valid  (rd_valid)
  );

  initial begin
    clk_mem = 1'b0;
    forever #(CLK_PERIOD / 2) clk_mem = ~clk_mem;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests finished");
    $display("** FAIL **");
    $fatal(1, "Simulation stopped by watchdog");
  end

  // A failed handshake or reset property ends the run
  always @(posedge clk_mem) begin
    if (matrix_multiplication_i.props_i.fail_count != 0) begin
      $display("Handshake or reset property failed");
      abort_run();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_elem(output elem_t v);
    for (int n = 0; n < ELEM_W; n++) begin
      v[n] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Low bits of the sum over k of A[i][k] * B[k][j]
  function automatic elem_t model_elem(input mat_t a, input mat_t b, input int i, input int j);
    int sum;
    sum = 0;
    for (int k = 0; k < MAT_SIZE; k++) begin
      sum += a[i][k] * b[k][j];
    end
    return sum[ELEM_W-1:0];
  endfunction

  // Column k of A
  function automatic row_t a_word(input mat_t a, input int k);
    row_t w;
    for (int i = 0; i < MAT_SIZE; i++) begin
      w[i*ELEM_W +: ELEM_W] = a[i][k];
    end
    return w;
  endfunction

  // Row k of B
  function automatic row_t b_word(input mat_t b, input int k);
    row_t w;
    for (int j = 0; j < MAT_SIZE; j++) begin
      w[j*ELEM_W +: ELEM_W] = b[k][j];
    end
    return w;
  endfunction

  task automatic next_cycle();
    @(posedge clk_mem);
    #2;
  endtask

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic fill_table();
    // With A = I the product is B
    tests[0] = '{name: "identity", load_a: 1'b1, load_b: 1'b1, use_lfsr: 1'b0,
                 poke_a: 1'b0, a: 128'h01000000_00010000_00000100_00000001,
                 b: 128'hf1e2d3c4_b5a69788_79605a4b_3c2d1e0f};
    // Every sum is 4 * 0xfe01 and wraps at 8 bits
    tests[1] = '{name: "all_ones_wrap", load_a: 1'b1, load_b: 1'b1, use_lfsr: 1'b0,
                 poke_a: 1'b0, a: '1, b: '1};
    tests[2] = '{name: "lfsr_both", load_a: 1'b1, load_b: 1'b1, use_lfsr: 1'b1,
                 poke_a: 1'b0, a: '0, b: '0};
    tests[3] = '{name: "reload_b_only", load_a: 1'b0, load_b: 1'b1, use_lfsr: 1'b1,
                 poke_a: 1'b1, a: '0, b: '0};
    tests[4] = '{name: "old_a_kept", load_a: 1'b0, load_b: 1'b1, use_lfsr: 1'b0,
                 poke_a: 1'b0, a: '0, b: 128'h01020304_05060708_090a0b0c_0d0e0f10};
  endtask

  //////////////////////////////////////////////////////////////////////
  // Load, compute and read back one table entry
  //////////////////////////////////////////////////////////////////////

  task automatic run_test(input int idx);
    test_t t;
    string nm;
    elem_t v;
    row_t  exp_row;
    int    cnt;
    t  = tests[idx];
    nm = string'(t.name);
    if (t.use_lfsr) begin
      for (int i = 0; i < MAT_SIZE; i++) begin
        for (int k = 0; k < MAT_SIZE; k++) begin
          if (t.load_a) begin
            rand_elem(v);
            t.a[i][k] = v;
          end
          if (t.load_b) begin
            rand_elem(v);
            t.b[i][k] = v;
          end
        end
      end
    end
    if (t.load_a) begin
      cur_a = t.a;
    end
    if (t.load_b) begin
      cur_b = t.b;
    end
    for (int k = 0; k < MAT_SIZE; k++) begin
      host_cmd = '{wr_a: t.load_a, wr_b: 1'b0, rd_c: 1'b0, addr: k, data: a_word(t.a, k)};
      if (t.load_a) next_cycle();
      host_cmd = '{wr_a: 1'b0, wr_b: t.load_b, rd_c: 1'b0, addr: k, data: b_word(t.b, k)};
      if (t.load_b) next_cycle();
    end
    host_cmd = '0;

    // Ack latency counts from the edge that samples req
    start_req = 1'b1;
    next_cycle();
    cnt = 0;
    while (!done_ack && cnt < MUL_LATENCY + 4) begin
      next_cycle();
      cnt++;
    end
    assert (cnt == MUL_LATENCY) else begin
      $display("ERROR %0s: ack latency expected %0d actual %0d", nm, MUL_LATENCY, cnt);
      abort_run();
    end

    // Writes while ack is high must not reach A
    if (t.poke_a) begin
      for (int k = 0; k < MAT_SIZE; k++) begin
        host_cmd = '{wr_a: 1'b1, wr_b: 1'b0, rd_c: 1'b0, addr: k, data: ~a_word(cur_a, k)};
        next_cycle();
        assert (done_ack) else begin
          $display("ERROR %0s: done_ack expected 1 actual %b while req held", nm, done_ack);
          abort_run();
        end
      end
    end
    start_req = 1'b0;
    host_cmd  = '0;
    next_cycle();
    assert (!done_ack) else begin
      $display("ERROR %0s: done_ack after req drop expected 0 actual %b", nm, done_ack);
      abort_run();
    end

    for (int r = 0; r < MAT_SIZE; r++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        exp_row[j*ELEM_W +: ELEM_W] = model_elem(cur_a, cur_b, r, j);
      end
      host_cmd = '{wr_a: 1'b0, wr_b: 1'b0, rd_c: 1'b1, addr: r, data: '0};
      next_cycle();
      host_cmd = '0;
      cnt = 1;
      while (!rd_valid && cnt < READ_LATENCY + 2) begin
        next_cycle();
        cnt++;
      end
      assert (cnt == READ_LATENCY) else begin
        $display("ERROR %0s: row %0d read latency expected %0d actual %0d",
                 nm, r, READ_LATENCY, cnt);
        abort_run();
      end
      assert (rd_data == exp_row) else begin
        $display("ERROR %0s: C row %0d expected %h actual %h", nm, r, exp_row, rd_data);
        abort_run();
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset     = 1'b1;
    start_req = 1'b0;
    host_cmd  = '0;
    lfsr      = SEED;
    cur_a     = '0;
    cur_b     = '0;
    fill_table();
    repeat (RESET_CYCLES) @(posedge clk_mem);
    #2;
    reset = 1'b0;
    next_cycle();
    assert (!done_ack && !rd_valid) else begin
      $display("ERROR reset: done_ack/rd_valid expected 0/0 actual %b/%b", done_ack, rd_valid);
      abort_run();
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    // Let the last property checks settle
    repeat (3) next_cycle();
    if (matrix_multiplication_i.props_i.fail_count != 0) begin
      $display("Handshake or reset property failed %0d times",
               matrix_multiplication_i.props_i.fail_count);
      $display("** FAIL **");
      $fatal(1, "Property failures seen");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// ==== verilog/mat_mul_ctrl.sv ====
`timescale 1ns/10ps

module mat_mul_ctrl
  import mat_pkg::*;
(
  input  logic  clk_mem,
  input  logic  reset,
  input  logic  start_req,
  output logic  done_ack,
  output logic  busy,
  output logic  clear,
  output addr_t feed_addr,
  output logic  operand_valid,
  output addr_t res_row,
  output logic  c_we
);

  ctrl_state_t state;

  // Counts feed words, drain cycles and written rows
  logic [$clog2(DRAIN_CYCLES)-1:0] step;

  //////////////////////////////////////////////////////////////////////
  // Sequence and handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_mem) begin
    if (reset) begin
      state    <= IDLE;
      step     <= '0;
      done_ack <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          step <= '0;
          if (start_req) begin
            state <= CLEAR;
          end
        end
        CLEAR: begin
          step  <= '0;
          state <= FEED;
        end
        FEED: begin
          if (step == MAT_SIZE - 1) begin
            step  <= '0;
            state <= DRAIN;
          end else begin
            step <= step + 1'b1;
          end
        end
        DRAIN: begin
          // Wait for the wavefront to reach the far corner
          if (step == DRAIN_CYCLES - 1) begin
            step  <= '0;
            state <= WRITE_C;
          end else begin
            step <= step + 1'b1;
          end
        end
        WRITE_C: begin
          if (step == MAT_SIZE - 1) begin
            step  <= '0;
            state <= DONE;
          end else begin
            step <= step + 1'b1;
          end
        end
        DONE: begin
          // Hold ack until the request goes away
          if (start_req) begin
            done_ack <= 1'b1;
          end else begin
            done_ack <= 1'b0;
            state    <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Memory data lags the feed address by one cycle
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      operand_valid <= 1'b0;
    end else begin
      operand_valid <= (state == FEED);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath controls
  //////////////////////////////////////////////////////////////////////

  assign busy      = (state != IDLE);
  assign clear     = (state == CLEAR);
  assign c_we      = (state == WRITE_C);
  assign feed_addr = step[ADDR_W-1:0];
  assign res_row   = step[ADDR_W-1:0];

endmodule

// ==== verilog/matrix_multiplication.sv ====
`timescale 1ns/10ps

module matrix_multiplication
  import mat_pkg::*;
(
  input  logic      clk_mem,
  input  logic      reset,
  input  host_cmd_t host_cmd,
  input  logic      start_req,
  output logic      done_ack,
  output row_t      rd_data,
  output logic      rd_valid
);

  // Controller outputs
  logic  busy;
  logic  clear;
  logic  operand_valid;
  logic  c_we;
  addr_t feed_addr;
  addr_t res_row;

  // Memory ports
  addr_t ab_addr;
  addr_t c_addr;
  row_t  a_rdata;
  row_t  b_rdata;
  row_t  c_rdata;
  row_t  res_data;

  // Read command in flight
  logic  rd_c_q;

  //////////////////////////////////////////////////////////////////////
  // Address muxing between host and controller
  //////////////////////////////////////////////////////////////////////

  assign ab_addr = busy ? feed_addr : host_cmd.addr;
  assign c_addr  = busy ? res_row   : host_cmd.addr;

  //////////////////////////////////////////////////////////////////////
  // Operand and result memories
  //////////////////////////////////////////////////////////////////////

  // Word k is column k of A
  row_ram mem_a (
    .clk_mem (clk_mem),
    .addr    (ab_addr),
    .wdata   (host_cmd.data),
    .we      (host_cmd.wr_a && !busy),
    .rdata   (a_rdata)
  );

  // Word k is row k of B
  row_ram mem_b (
    .clk_mem (clk_mem),
    .addr    (ab_addr),
    .wdata   (host_cmd.data),
    .we      (host_cmd.wr_b && !busy),
    .rdata   (b_rdata)
  );

  // Word i is row i of C
  row_ram mem_c (
    .clk_mem (clk_mem),
    .addr    (c_addr),
    .wdata   (res_data),
    .we      (c_we),
    .rdata   (c_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // Compute
  //////////////////////////////////////////////////////////////////////

  systolic_array array_i (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .clear         (clear),
    .a_col         (a_rdata),
    .b_row         (b_rdata),
    .operand_valid (operand_valid),
    .res_row       (res_row),
    .res_data      (res_data)
  );

  mat_mul_ctrl ctrl_i (
    .clk_mem       (clk_mem),
    .reset         (reset),
    .start_req     (start_req),
    .done_ack      (done_ack),
    .busy          (busy),
    .clear         (clear),
    .feed_addr     (feed_addr),
    .operand_valid (operand_valid),
    .res_row       (res_row),
    .c_we          (c_we)
  );

  //////////////////////////////////////////////////////////////////////
  // Host read-back
  //////////////////////////////////////////////////////////////////////

  // Reads only count while idle
  always_ff @(posedge clk_mem) begin
    if (reset) begin
      rd_c_q   <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      rd_c_q   <= host_cmd.rd_c && !busy;
      rd_valid <= rd_c_q;
    end
  end

  // Data held until the next read
  always_ff @(posedge clk_mem) begin
    if (rd_c_q) begin
      rd_data <= c_rdata;
    end
  end

endmodule

// ==== verilog/row_ram.sv ====
`timescale 1ns/10ps

module row_ram
  import mat_pkg::*;
(
  input  logic  clk_mem,
  input  addr_t addr,
  input  row_t  wdata,
  input  logic  we,
  output row_t  rdata
);

  // MAT_SIZE words, one row or column each
  row_t mem [MAT_SIZE];

  // Read first, so a write returns the old word
  always_ff @(posedge clk_mem) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule
